//--- rtl/mulPkg.sv
// fixed 32x32 to 64-bit multiply with both operands signed or both unsigned, no mixed mode
`default_nettype none

package mulPkg;

    // operand and product widths
    localparam int OPW = 32;
    localparam int PRODW = 2 * OPW;

    // one extra digit so an unsigned multiplier with its top bit set
    // still gets a positive recoding for that bit
    localparam int NUMDIGITS = OPW / 2 + 1;

    // product word, read whole or as two halves
    // the halves feed the overflow rule
    typedef union packed {
        logic [PRODW-1:0] whole;
        struct packed {
            logic [OPW-1:0] hi;
            logic [OPW-1:0] lo;
        } halves;
    } prodWord_t;

endpackage

`default_nettype wire

//--- rtl/boothPartialProducts.sv
// combinational radix-4 Booth rows, each a full 64-bit two's complement term with no correction bits
`default_nettype none

module boothPartialProducts (
    input  logic [mulPkg::OPW-1:0]                         a,
    input  logic [mulPkg::OPW-1:0]                         b,
    input  logic                                           sign,
    output logic [mulPkg::NUMDIGITS-1:0][mulPkg::PRODW-1:0] rows
);
    import mulPkg::*;

    // multiplier with an implied zero below bit 0 and two extension bits on top
    logic [OPW+2:0]   bExt;
    logic             bTop;

    // multiplicand extended once to product width
    logic [PRODW-1:0] aWide;
    logic             aTop;

    assign bTop = sign & b[OPW-1];
    assign bExt = {bTop, bTop, b, 1'b0};

    assign aTop = sign & a[OPW-1];
    assign aWide = {{(PRODW - OPW){aTop}}, a};

    for (genvar i = 0; i < NUMDIGITS; i++) begin : gDigit
        logic [2:0]       win;
        logic             neg;
        logic             zero;
        logic             one;
        logic             two;
        logic [PRODW-1:0] mag;
        logic [PRODW-1:0] term;

        // overlapping window b[2i+1], b[2i], b[2i-1]
        assign win = bExt[2*i+2 -: 3];

        // digit in -2..+2 as flags
        assign neg  = win[2] & ~(win[1] & win[0]);
        assign one  = win[1] ^ win[0];
        assign two  = (win[2] & ~win[1] & ~win[0]) | (~win[2] & win[1] & win[0]);
        assign zero = ~one & ~two;

        // magnitude a, 2a or nothing
        always_comb begin
            if (zero) begin
                mag = '0;
            end else if (two) begin
                mag = aWide << 1;
            end else begin
                mag = aWide;
            end
        end

        // full negation here keeps the tree free of hot-one bits
        assign term = neg ? (~mag + 1'b1) : mag;

        // weight 4^i
        assign rows[i] = term << (2 * i);
    end

endmodule

`default_nettype wire

//--- rtl/wallaceTree.sv
// combinational carry-save tree, sum and carry are only valid modulo 2^64 and must be added afterwards
`default_nettype none

module wallaceTree (
    input  logic [mulPkg::NUMDIGITS-1:0][mulPkg::PRODW-1:0] rows,
    output logic [mulPkg::PRODW-1:0]                        sum,
    output logic [mulPkg::PRODW-1:0]                        carry
);
    import mulPkg::*;

    // rows left after one 3:2 level
    function automatic int nextCount(int n);
        return 2 * (n / 3) + n % 3;
    endfunction

    // rows present at the input of a given level
    function automatic int countAt(int lvlIdx);
        int n;
        n = NUMDIGITS;
        for (int k = 0; k < lvlIdx; k++) begin
            n = nextCount(n);
        end
        return n;
    endfunction

    // number of levels until two rows remain
    function automatic int levelCount();
        int n;
        int lv;
        n = NUMDIGITS;
        lv = 0;
        while (n > 2) begin
            n = nextCount(n);
            lv++;
        end
        return lv;
    endfunction

    // 17 -> 12 -> 8 -> 6 -> 4 -> 3 -> 2
    logic [NUMDIGITS-1:0][PRODW-1:0] lvl [0:levelCount()];

    assign lvl[0] = rows;

    for (genvar l = 0; l < levelCount(); l++) begin : gLevel

        // groups of three rows into sum and shifted carry
        for (genvar g = 0; g < countAt(l) / 3; g++) begin : gCsa
            logic [PRODW-1:0] x;
            logic [PRODW-1:0] y;
            logic [PRODW-1:0] z;
            logic [PRODW-1:0] maj;

            assign x = lvl[l][3*g];
            assign y = lvl[l][3*g+1];
            assign z = lvl[l][3*g+2];

            assign maj = (x & y) | (x & z) | (y & z);

            assign lvl[l+1][2*g]   = x ^ y ^ z;
            // carry past bit 63 falls off
            assign lvl[l+1][2*g+1] = {maj[PRODW-2:0], 1'b0};
        end

        // leftover rows go straight to the next level
        for (genvar p = 0; p < countAt(l) % 3; p++) begin : gPass
            assign lvl[l+1][2*(countAt(l)/3)+p] = lvl[l][3*(countAt(l)/3)+p];
        end

        // slots that the shrinking level no longer fills
        for (genvar u = countAt(l+1); u < NUMDIGITS; u++) begin : gIdle
            assign lvl[l+1][u] = '0;
        end
    end

    assign sum   = lvl[levelCount()][0];
    assign carry = lvl[levelCount()][1];

endmodule

`default_nettype wire

//--- rtl/carryPropagateAdder.sv
// combinational 64-bit add with no carry in and no carry out, groups ripple so depth grows with width
`default_nettype none

module carryPropagateAdder (
    input  logic [mulPkg::PRODW-1:0] x,
    input  logic [mulPkg::PRODW-1:0] y,
    output logic [mulPkg::PRODW-1:0] sum
);
    import mulPkg::*;

    // carry into each 4-bit group
    logic [PRODW/4-1:0] gc;

    assign gc[0] = 1'b0;

    for (genvar k = 0; k < PRODW / 4; k++) begin : gGroup
        logic [3:0] gen;
        logic [3:0] prop;
        logic [3:0] c;

        assign gen  = x[4*k +: 4] & y[4*k +: 4];
        assign prop = x[4*k +: 4] ^ y[4*k +: 4];

        // lookahead inside the group
        assign c[0] = gc[k];
        assign c[1] = gen[0] | (prop[0] & c[0]);
        assign c[2] = gen[1] | (prop[1] & gen[0]) | (prop[1] & prop[0] & c[0]);
        assign c[3] = gen[2] | (prop[2] & gen[1]) | (prop[2] & prop[1] & gen[0])
                    | (prop[2] & prop[1] & prop[0] & c[0]);

        assign sum[4*k +: 4] = prop ^ c;

        // the top group has no successor, product is complete in 64 bits
        if (k < PRODW / 4 - 1) begin : gCarryOut
            assign gc[k+1] = gen[3] | (prop[3] & gen[2]) | (prop[3] & prop[2] & gen[1])
                           | (prop[3] & prop[2] & prop[1] & gen[0])
                           | (prop[3] & prop[2] & prop[1] & prop[0] & c[0]);
        end
    end

endmodule

`default_nettype wire

//--- rtl/mulUnit.sv
// fixed two-cycle latency with no back-pressure so each result must be taken while outVld is high
`default_nettype none

module mulUnit (
    input  logic                     clk,
    input  logic                     arstN,
    input  logic                     inVld,
    input  logic [mulPkg::OPW-1:0]   a,
    input  logic [mulPkg::OPW-1:0]   b,
    input  logic                     sign,
    output logic                     outVld,
    output logic [mulPkg::PRODW-1:0] prod,
    output logic                     overflow
);
    import mulPkg::*;

    logic [NUMDIGITS-1:0][PRODW-1:0] rows;
    logic [PRODW-1:0]                treeSum;
    logic [PRODW-1:0]                treeCarry;

    // stage 1, carry-save pair
    logic                            s1Vld;
    logic                            s1Sign;
    logic [PRODW-1:0]                s1Sum;
    logic [PRODW-1:0]                s1Carry;

    logic [PRODW-1:0]                cpaSum;
    prodWord_t                       cpaWord;
    logic                            ovfNext;

    // stage 2, final product
    prodWord_t                       s2Word;

    boothPartialProducts booth0 (
        .a    (a),
        .b    (b),
        .sign (sign),
        .rows (rows)
    );

    wallaceTree tree0 (
        .rows  (rows),
        .sum   (treeSum),
        .carry (treeCarry)
    );

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            s1Vld   <= 1'b0;
            s1Sign  <= 1'b0;
            s1Sum   <= '0;
            s1Carry <= '0;
        end else begin
            s1Vld <= inVld;
            if (inVld) begin
                s1Sign  <= sign;
                s1Sum   <= treeSum;
                s1Carry <= treeCarry;
            end
        end
    end

    carryPropagateAdder cpa0 (
        .x   (s1Sum),
        .y   (s1Carry),
        .sum (cpaSum)
    );

    assign cpaWord.whole = cpaSum;

    // signed needs hi to be the sign extension of lo, unsigned needs hi zero
    assign ovfNext = s1Sign ? (cpaWord.halves.hi != {OPW{cpaWord.halves.lo[OPW-1]}})
                            : (cpaWord.halves.hi != '0);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outVld   <= 1'b0;
            overflow <= 1'b0;
            s2Word   <= '0;
        end else begin
            outVld <= s1Vld;
            // hold the last result between strobes
            if (s1Vld) begin
                overflow <= ovfNext;
                s2Word   <= cpaWord;
            end
        end
    end

    assign prod = s2Word.whole;

    // every result strobe comes from an operation accepted two cycles earlier
    asrtVldChain : assert property (@(posedge clk) disable iff (!arstN)
        outVld |-> $past(inVld, 2))
        else $error("outVld without an operation accepted two cycles earlier");

    asrtProdKnown : assert property (@(posedge clk) disable iff (!arstN)
        outVld |-> !$isunknown(prod))
        else $error("prod has unknown bits while outVld is high");

    asrtResetQuiet : assert property (@(posedge clk)
        !arstN |-> !outVld)
        else $error("outVld high during reset");

endmodule

`default_nettype wire

//--- sim/mulUnitTb.sv
// results are sampled on the falling clock edge, operands are held for a single cycle each
`default_nettype none

module mulUnitTb;
    import mulPkg::*;

    localparam int RSTCYCLES    = 16;
    localparam int NUMRAND      = 1000;
    localparam int NUMCORNER    = 7;
    localparam int NUMOVF       = 200;
    localparam int NUMBURST     = 20;
    localparam int MAXBURST     = 12;
    localparam int MAXGAP       = 5;
    localparam int MIDRSTCYCLES = 4;
    localparam int MIDRSTOPS    = 10;
    localparam int NUMDRAIN     = 6;

    // one cycle per issue or idle, a few more per drain
    localparam int CYCLELIMIT = RSTCYCLES + 2 * NUMRAND + 2 * NUMCORNER * NUMCORNER
        + 2 * NUMOVF + NUMBURST * (MAXBURST + MAXGAP) + MIDRSTCYCLES + 2 * MIDRSTOPS
        + NUMDRAIN * 8 + 100;

    logic             clk;
    logic             arstN;
    logic             inVld;
    logic [OPW-1:0]   a;
    logic [OPW-1:0]   b;
    logic             sign;
    logic             outVld;
    logic [PRODW-1:0] prod;
    logic             overflow;

    int               cyc;
    int               errCount;

    // expected results in issue order
    logic [PRODW-1:0] expProd [$];
    logic             expOvf [$];
    int               expDue [$];

    mulUnit dut0 (
        .clk      (clk),
        .arstN    (arstN),
        .inVld    (inVld),
        .a        (a),
        .b        (b),
        .sign     (sign),
        .outVld   (outVld),
        .prod     (prod),
        .overflow (overflow)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cyc = cyc + 1;
        if (cyc >= CYCLELIMIT) begin
            $display("timeout after %0d cycles with %0d results outstanding", cyc,
                     expDue.size());
            $display("errors: %0d", errCount + 1);
            $display("tests failed");
            $finish;
        end
    end

    // full product of the extended operands, kept to 64 bits
    function automatic logic [PRODW-1:0] modelProduct(input logic [OPW-1:0] x,
                                                      input logic [OPW-1:0] y,
                                                      input logic s);
        logic [PRODW-1:0] xw;
        logic [PRODW-1:0] yw;
        xw = s ? {{(PRODW - OPW){x[OPW-1]}}, x} : {{(PRODW - OPW){1'b0}}, x};
        yw = s ? {{(PRODW - OPW){y[OPW-1]}}, y} : {{(PRODW - OPW){1'b0}}, y};
        return xw * yw;
    endfunction

    function automatic logic modelOverflow(input logic [PRODW-1:0] p, input logic s);
        if (s) begin
            return p[PRODW-1:OPW] != {(PRODW - OPW){p[OPW-1]}};
        end
        return p[PRODW-1:OPW] != '0;
    endfunction

    function automatic logic [OPW-1:0] cornerValue(input int idx);
        case (idx)
            0:       return 32'h0000_0000;
            1:       return 32'h0000_0001;
            2:       return 32'hffff_ffff;
            3:       return 32'h8000_0000;
            4:       return 32'h7fff_ffff;
            5:       return 32'haaaa_aaaa;
            default: return 32'h5555_5555;
        endcase
    endfunction

    task automatic checkValue(input string name, input logic [PRODW-1:0] expected,
                              input logic [PRODW-1:0] actual);
        if (actual !== expected) begin
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
            errCount++;
        end
    endtask

    task automatic issue(input logic [OPW-1:0] x, input logic [OPW-1:0] y, input logic s);
        @(posedge clk);
        #2;
        inVld = 1'b1;
        a     = x;
        b     = y;
        sign  = s;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
            inVld = 1'b0;
        end
    endtask

    // wait for every result in flight
    task automatic drain();
        idle(1);
        while (expDue.size() != 0) begin
            @(posedge clk);
        end
        idle(2);
    endtask

    always @(negedge clk) begin : monitor
        logic [PRODW-1:0] p;
        logic             o;
        int               due;
        if (!arstN) begin
            checkValue("outVld", '0, 64'(outVld));
            expProd.delete();
            expOvf.delete();
            expDue.delete();
        end else begin
            if (outVld) begin
                if (expDue.size() == 0) begin
                    $display("result at cycle %0d with no operation in flight", cyc);
                    errCount++;
                end else begin
                    p   = expProd.pop_front();
                    o   = expOvf.pop_front();
                    due = expDue.pop_front();
                    checkValue("outVld cycle", 64'(due), 64'(cyc));
                    checkValue("prod", p, prod);
                    checkValue("overflow", 64'(o), 64'(overflow));
                end
            end else if (expDue.size() != 0 && expDue[0] <= cyc) begin
                $display("result due at cycle %0d never arrived", expDue[0]);
                errCount++;
                void'(expProd.pop_front());
                void'(expOvf.pop_front());
                void'(expDue.pop_front());
            end
            // sampled on the next rising edge, strobe one edge after that
            if (inVld) begin
                p = modelProduct(a, b, sign);
                expProd.push_back(p);
                expOvf.push_back(modelOverflow(p, sign));
                expDue.push_back(cyc + 2);
            end
        end
    end

    initial begin
        int             len;
        int             gap;
        logic [OPW-1:0] rnd;
        logic [OPW-1:0] x;
        logic [OPW-1:0] y;

        clk      = 1'b0;
        arstN    = 1'b0;
        inVld    = 1'b0;
        a        = '0;
        b        = '0;
        sign     = 1'b0;
        cyc      = 0;
        errCount = 0;
        void'($urandom(32'h730c));

        repeat (RSTCYCLES) @(posedge clk);
        #2;
        arstN = 1'b1;

        for (int i = 0; i < NUMRAND; i++) begin
            issue($urandom, $urandom, 1'b1);
        end
        drain();

        // every fourth multiplier has its top bit set
        for (int i = 0; i < NUMRAND; i++) begin
            y = $urandom;
            if (i % 4 == 0) begin
                y[OPW-1] = 1'b1;
            end
            issue($urandom, y, 1'b0);
        end
        drain();

        for (int s = 0; s < 2; s++) begin
            for (int i = 0; i < NUMCORNER; i++) begin
                for (int j = 0; j < NUMCORNER; j++) begin
                    issue(cornerValue(i), cornerValue(j), s == 1);
                end
            end
        end
        drain();

        // small products that fit, then large ones that mostly do not
        for (int i = 0; i < NUMOVF; i++) begin
            rnd = $urandom;
            if (rnd[31]) begin
                x = {{(OPW - 12){rnd[11]}}, rnd[11:0]};
                y = {{(OPW - 12){rnd[27]}}, rnd[27:16]};
                issue(x, y, 1'b1);
            end else begin
                x = {{(OPW - 12){1'b0}}, rnd[11:0]};
                y = {{(OPW - 12){1'b0}}, rnd[27:16]};
                issue(x, y, 1'b0);
            end
            issue($urandom, $urandom, rnd[30]);
        end
        drain();

        for (int k = 0; k < NUMBURST; k++) begin
            len = 1 + $urandom_range(MAXBURST - 1, 0);
            gap = 1 + $urandom_range(MAXGAP - 1, 0);
            for (int j = 0; j < len; j++) begin
                rnd = $urandom;
                issue($urandom, $urandom, rnd[0]);
            end
            idle(gap);
        end
        drain();

        // reset while a burst is in flight
        for (int i = 0; i < MIDRSTOPS; i++) begin
            rnd = $urandom;
            issue($urandom, $urandom, rnd[0]);
        end
        @(posedge clk);
        #2;
        arstN = 1'b0;
        repeat (MIDRSTCYCLES) @(posedge clk);
        #2;
        arstN = 1'b1;
        inVld = 1'b0;
        for (int i = 0; i < MIDRSTOPS; i++) begin
            rnd = $urandom;
            issue($urandom, $urandom, rnd[0]);
        end
        drain();

        if (expDue.size() != 0) begin
            $display("%0d expected results were left over at the end", expDue.size());
            errCount++;
        end

        $display("errors: %0d", errCount);
        if (errCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
rtl/mulPkg.sv
rtl/boothPartialProducts.sv
rtl/wallaceTree.sv
rtl/carryPropagateAdder.sv
rtl/mulUnit.sv
sim/mulUnitTb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := mulUnitTb
FILELIST  := src.f
OBJDIR    := obj_dir
PASSMSG   := all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -Fqx "$(PASSMSG)"

clean:
	rm -rf $(OBJDIR)
